// ==== flist.f ====
+incdir+logic
logic/soc_pkg.sv
logic/rst_sequencer.sv
logic/wbpi_decoder.sv
logic/devtbl.sv
logic/gpio_port.sv
logic/activity_dimmer.sv
logic/soc_periph_top.sv
verification/tb_clkgen.sv
verification/wbpi_props.sv
verification/tb_soc_periph.sv

// ==== logic/activity_dimmer.sv ====
// Activity indicator pulse with blanking counter for dimming
`timescale 1ns/100ps
`include "soc_defines.svh"

module activity_dimmer (
	input logic clk_2x_w,
	input logic sys_rst_i,
	input logic event_i,
	output logic activity_o
);

	logic [`SOC_ACTIVITY_CNTR_BITSZ-1:0] blank_cntr_q;
	logic activity_q;

	// One pulse, then events are ignored until the counter runs out
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			blank_cntr_q <= '0;
			activity_q <= 1'b0;
		end else if (blank_cntr_q != '0) begin
			blank_cntr_q <= blank_cntr_q - 1'b1;
			activity_q <= 1'b0;
		end else if (event_i) begin
			blank_cntr_q <= '1;
			activity_q <= 1'b1;
		end else begin
			activity_q <= 1'b0;
		end
	end

	assign activity_o = activity_q;

endmodule

// ==== logic/devtbl.sv ====
// Device table slave with constant device list and software reset register
`timescale 1ns/100ps
`include "soc_defines.svh"

module devtbl (
	input logic clk_2x_w,
	input logic devtbl_rst2_w,
	input soc_pkg::wb_req_t req_i,
	output soc_pkg::wb_rsp_t rsp_o,
	output soc_pkg::rst_req_t rst_req_o
);

	logic [`SOC_REGION_WBITS-1:0] word_idx;
	logic access;
	soc_pkg::devtbl_entry_t entry;
	logic ack_q;
	soc_pkg::data_t dat_q;
	soc_pkg::rst_req_t rst_req_q;

	assign word_idx = req_i.addr[`SOC_REGION_WBITS-1:0];

	// First cycle of a strobe, ack follows on the next cycle
	assign access = req_i.stb && !ack_q;

	// Constant device list, one word per slave
	always_comb begin
		entry = '0;
		if (word_idx == `SOC_REGION_WBITS'(`SOC_S_DEVTBL)) begin
			entry.useirq = 1'b0;
			entry.id = soc_pkg::dev_id_t'(`SOC_ID_DEVTBL);
		end else if (word_idx == `SOC_REGION_WBITS'(`SOC_S_GP0IO) ||
			word_idx == `SOC_REGION_WBITS'(`SOC_S_GP1IO)) begin
			entry.useirq = 1'b1;
			entry.id = soc_pkg::dev_id_t'(`SOC_ID_GPIO);
		end else begin
			entry.useirq = 1'b0;
			entry.id = soc_pkg::dev_id_t'(`SOC_ID_INVALID);
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (devtbl_rst2_w) begin
			ack_q <= 1'b0;
			rst_req_q <= '0;
		end else begin
			ack_q <= access;
			// Write to word 0 raises a one-cycle reset request
			rst_req_q.valid <= access && req_i.we && (word_idx == '0);
			rst_req_q.rst0 <= req_i.dat[0];
			rst_req_q.rst1 <= req_i.dat[1];
		end
	end

	// Read data, zero above the last slave
	always_ff @(posedge clk_2x_w) begin
		if (access) begin
			dat_q <= soc_pkg::data_t'(entry);
		end
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.dat = dat_q;
	assign rst_req_o = rst_req_q;

endmodule

// ==== logic/gpio_port.sv ====
// Bus-mapped GPIO port with input synchroniser and input change interrupt
`timescale 1ns/100ps
`include "soc_defines.svh"

module gpio_port #(
	parameter int IOCOUNT = 16
) (
	input logic clk_2x_w,
	input logic sys_rst_i,
	input soc_pkg::wb_req_t req_i,
	output soc_pkg::wb_rsp_t rsp_o,
	input logic [IOCOUNT-1:0] io_i,
	output logic [IOCOUNT-1:0] io_o,
	output logic irq_o
);

	logic [`SOC_REGION_WBITS-1:0] word_idx;
	logic access;
	logic [IOCOUNT-1:0] in_meta_q;
	logic [IOCOUNT-1:0] in_sync_q;
	logic [IOCOUNT-1:0] in_prev_q;
	logic [IOCOUNT-1:0] out_q;
	soc_pkg::data_t wr_merge;
	logic ack_q;
	logic irq_q;
	soc_pkg::data_t dat_q;

	assign word_idx = req_i.addr[`SOC_REGION_WBITS-1:0];
	assign access = req_i.stb && !ack_q;

	// Two-flop synchroniser, previous value kept for change detection
	always_ff @(posedge clk_2x_w) begin
		in_meta_q <= io_i;
		in_sync_q <= in_meta_q;
		in_prev_q <= in_sync_q;
	end

	// Byte-enable merge of the write data into the output register
	always_comb begin
		wr_merge = soc_pkg::data_t'(out_q);
		for (int b = 0; b < `SOC_ARCHBITSZ/8; b++) begin
			if (req_i.sel[b]) begin
				wr_merge[b*8 +: 8] = req_i.dat[b*8 +: 8];
			end
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			ack_q <= 1'b0;
			irq_q <= 1'b0;
			out_q <= '0;
		end else begin
			ack_q <= access;
			irq_q <= (in_sync_q != in_prev_q);
			if (access && req_i.we && word_idx == `SOC_REGION_WBITS'(1)) begin
				out_q <= wr_merge[IOCOUNT-1:0];
			end
		end
	end

	// Word 0 inputs, word 1 outputs, other words read as zero
	always_ff @(posedge clk_2x_w) begin
		if (access) begin
			if (word_idx == '0) begin
				dat_q <= soc_pkg::data_t'(in_sync_q);
			end else if (word_idx == `SOC_REGION_WBITS'(1)) begin
				dat_q <= soc_pkg::data_t'(out_q);
			end else begin
				dat_q <= '0;
			end
		end
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.dat = dat_q;
	assign io_o = out_q;
	assign irq_o = irq_q;

endmodule

// ==== logic/rst_sequencer.sv ====
// Software reset decode, reset hold-off counter and power-off latch
`timescale 1ns/100ps
`include "soc_defines.svh"

module rst_sequencer (
	input logic clk_2x_w,
	input logic devtbl_rst2_w,
	input soc_pkg::rst_req_t rst_req_i,
	output logic sys_rst_o,
	output logic pwroff_o
);

	logic sw_cold_rst;
	logic sw_warm_rst;
	logic sw_pwroff;
	logic [`SOC_RST_CNTR_BITSZ-1:0] rst_cntr_q;
	logic pwroff_q;

	// Request decode
	assign sw_cold_rst = rst_req_i.valid && rst_req_i.rst0 && rst_req_i.rst1;
	assign sw_warm_rst = rst_req_i.valid && !rst_req_i.rst0 && rst_req_i.rst1;
	assign sw_pwroff = rst_req_i.valid && rst_req_i.rst0 && !rst_req_i.rst1;

	// Hold-off counter, reloaded by the board reset or a cold/warm request
	always_ff @(posedge clk_2x_w) begin
		if (devtbl_rst2_w || sw_cold_rst || sw_warm_rst) begin
			rst_cntr_q <= '1;
		end else if (rst_cntr_q != '0) begin
			rst_cntr_q <= rst_cntr_q - 1'b1;
		end
	end

	// Power-off stays latched until the next board reset
	always_ff @(posedge clk_2x_w) begin
		if (devtbl_rst2_w) begin
			pwroff_q <= 1'b0;
		end else if (sw_pwroff) begin
			pwroff_q <= 1'b1;
		end
	end

	// A powered-off system is kept in reset as well
	assign sys_rst_o = (rst_cntr_q != '0) || pwroff_q;
	assign pwroff_o = pwroff_q;

endmodule

// ==== logic/soc_defines.svh ====
// Data and address widths, counter sizes, slave map and device id macros
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// Bus widths
`define SOC_ARCHBITSZ 32
`define SOC_ADDRBITSZ 30
`define SOC_DEVID_BITSZ 16

// Counter widths
`define SOC_RST_CNTR_BITSZ 4
`define SOC_ACTIVITY_CNTR_BITSZ 7

// GPIO port widths
`define SOC_GP0IOCOUNT 16
`define SOC_GP1IOCOUNT 5

// Slave indices, slave n decodes region n
`define SOC_SLAVECOUNT 4
`define SOC_S_DEVTBL 0
`define SOC_S_GP0IO 1
`define SOC_S_GP1IO 2
`define SOC_S_INVALID 3

// Word address bits inside one 4 KB region
`define SOC_REGION_WBITS 10

// Device ids reported by the device table
`define SOC_ID_DEVTBL 7
`define SOC_ID_GPIO 6
`define SOC_ID_INVALID 0

`endif

// ==== logic/soc_periph_top.sv ====
// Peripheral SoC top level with reset sequencer, bus decoder and slaves
`timescale 1ns/100ps
`include "soc_defines.svh"

module soc_periph_top (
	input logic clk_2x_w,
	input logic devtbl_rst2_w,
	input soc_pkg::wb_req_t wb_req_i,
	output soc_pkg::wb_rsp_t wb_rsp_o,
	input logic [`SOC_GP0IOCOUNT-1:0] gp0_i,
	output logic [`SOC_GP0IOCOUNT-1:0] gp0_o,
	input logic [`SOC_GP1IOCOUNT-1:0] gp1_i,
	output logic [1:0] gp_irq_o,
	output logic activity_o,
	output logic sys_rst_o,
	output logic pwroff_o
);

	soc_pkg::wb_req_t s_req_w [`SOC_SLAVECOUNT];
	soc_pkg::wb_rsp_t s_rsp_w [`SOC_SLAVECOUNT];
	soc_pkg::rst_req_t rst_req_w;

	rst_sequencer i_rst_sequencer (
		.clk_2x_w (clk_2x_w),
		.devtbl_rst2_w (devtbl_rst2_w),
		.rst_req_i (rst_req_w),
		.sys_rst_o (sys_rst_o),
		.pwroff_o (pwroff_o)
	);

	wbpi_decoder i_wbpi_decoder (
		.clk_2x_w (clk_2x_w),
		.sys_rst_i (sys_rst_o),
		.m_req_i (wb_req_i),
		.m_rsp_o (wb_rsp_o),
		.s_req_o (s_req_w),
		.s_rsp_i (s_rsp_w)
	);

	// Device table runs on the board reset so a software reset
	// does not clear its own request
	devtbl i_devtbl (
		.clk_2x_w (clk_2x_w),
		.devtbl_rst2_w (devtbl_rst2_w),
		.req_i (s_req_w[`SOC_S_DEVTBL]),
		.rsp_o (s_rsp_w[`SOC_S_DEVTBL]),
		.rst_req_o (rst_req_w)
	);

	// Switches and LEDs
	gpio_port #(
		.IOCOUNT (`SOC_GP0IOCOUNT)
	) i_gp0io (
		.clk_2x_w (clk_2x_w),
		.sys_rst_i (sys_rst_o),
		.req_i (s_req_w[`SOC_S_GP0IO]),
		.rsp_o (s_rsp_w[`SOC_S_GP0IO]),
		.io_i (gp0_i),
		.io_o (gp0_o),
		.irq_o (gp_irq_o[0])
	);

	// Buttons, input only
	gpio_port #(
		.IOCOUNT (`SOC_GP1IOCOUNT)
	) i_gp1io (
		.clk_2x_w (clk_2x_w),
		.sys_rst_i (sys_rst_o),
		.req_i (s_req_w[`SOC_S_GP1IO]),
		.rsp_o (s_rsp_w[`SOC_S_GP1IO]),
		.io_i (gp1_i),
		.io_o (),
		.irq_o (gp_irq_o[1])
	);

	// Invalid device catches unmapped accesses and never answers
	assign s_rsp_w[`SOC_S_INVALID] = '0;

	// Every acknowledged access counts as activity
	activity_dimmer i_activity_dimmer (
		.clk_2x_w (clk_2x_w),
		.sys_rst_i (sys_rst_o),
		.event_i (wb_rsp_o.ack),
		.activity_o (activity_o)
	);

endmodule

// ==== logic/soc_pkg.sv ====
// Bus request and response, reset request and device table entry types
`include "soc_defines.svh"

package soc_pkg;

	// Plain widths of the 32-bit peripheral bus
	typedef logic [`SOC_ARCHBITSZ-1:0] data_t;
	typedef logic [`SOC_ADDRBITSZ-1:0] waddr_t;
	typedef logic [`SOC_ARCHBITSZ/8-1:0] sel_t;

	// Index of a slave on the interconnect
	typedef logic [$clog2(`SOC_SLAVECOUNT)-1:0] slv_idx_t;

	// Device id as stored in the device table
	typedef logic [`SOC_DEVID_BITSZ-1:0] dev_id_t;

	// Master to slave, held until ack
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		waddr_t addr;
		sel_t sel;
		data_t dat;
	} wb_req_t;

	// Slave to master, ack is a single cycle pulse
	typedef struct packed {
		logic ack;
		data_t dat;
	} wb_rsp_t;

	// Software reset request, valid for one cycle
	// rst0 and rst1 together request a cold reset
	typedef struct packed {
		logic valid;
		logic rst0;
		logic rst1;
	} rst_req_t;

	// One device table word before zero extension
	typedef struct packed {
		logic useirq;
		dev_id_t id;
	} devtbl_entry_t;

endpackage

// ==== logic/wbpi_decoder.sv ====
// Peripheral bus decoder with request routing and response multiplexer
`timescale 1ns/100ps
`include "soc_defines.svh"

module wbpi_decoder (
	// Only sampled by the bound protocol checks
	input logic clk_2x_w,
	input logic sys_rst_i,
	input soc_pkg::wb_req_t m_req_i,
	output soc_pkg::wb_rsp_t m_rsp_o,
	output soc_pkg::wb_req_t s_req_o [`SOC_SLAVECOUNT],
	input soc_pkg::wb_rsp_t s_rsp_i [`SOC_SLAVECOUNT]
);

	localparam int REGION_BITSZ = `SOC_ADDRBITSZ - `SOC_REGION_WBITS;

	logic [REGION_BITSZ-1:0] region;
	soc_pkg::slv_idx_t slv_sel;
	logic sel_invalid;

	// Region n maps to slave n, everything from the invalid index upward
	// falls into the invalid device
	assign region = m_req_i.addr[`SOC_ADDRBITSZ-1:`SOC_REGION_WBITS];

	always_comb begin
		if (region < REGION_BITSZ'(`SOC_S_INVALID)) begin
			slv_sel = soc_pkg::slv_idx_t'(region);
		end else begin
			slv_sel = soc_pkg::slv_idx_t'(`SOC_S_INVALID);
		end
	end

	assign sel_invalid = (slv_sel == soc_pkg::slv_idx_t'(`SOC_S_INVALID));

	// Every slave sees address and data, cyc and stb go to the selected one
	always_comb begin
		for (int i = 0; i < `SOC_SLAVECOUNT; i++) begin
			s_req_o[i] = m_req_i;
			if (soc_pkg::slv_idx_t'(i) == slv_sel) begin
				// No new access starts while the system is in reset
				s_req_o[i].stb = m_req_i.stb && !sys_rst_i;
			end else begin
				s_req_o[i].cyc = 1'b0;
				s_req_o[i].stb = 1'b0;
			end
		end
	end

	// Response from the selected slave, the invalid device stays silent
	always_comb begin
		if (sel_invalid) begin
			m_rsp_o = '0;
		end else begin
			m_rsp_o = s_rsp_i[slv_sel];
		end
	end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Compile with Verilator and run the testbench, pass only on the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_soc_periph -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_soc_periph)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "TEST OK"; then
	exit 0
fi
exit 1

// ==== verification/tb_clkgen.sv ====
// Free-running clock source for the testbench
`timescale 1ns/100ps

module tb_clkgen #(
	parameter int PERIOD_NS = 10
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk_o = ~clk_o;
		end
	end

endmodule

// ==== verification/tb_soc_periph.sv ====
// Directed testbench for the peripheral SoC with compare tasks and watchdog
`timescale 1ns/100ps
`include "soc_defines.svh"

module tb_soc_periph;

	localparam int CLK_PERIOD_NS = 10;
	localparam int DRIVE_DELAY_NS = 1;
	localparam int TEST_COUNT = 6;
	localparam int CYCLES_PER_TEST = 2000;
	localparam int WATCHDOG_NS = TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD_NS;
	localparam int RST_HOLD_CYCLES = 5;
	localparam int ACK_WAIT_CYCLES = 8;
	// Hold-off and blanking counters restart from all ones
	localparam int RST_HOLDOFF = (1 << `SOC_RST_CNTR_BITSZ) - 1;
	localparam int BLANK_CYCLES = (1 << `SOC_ACTIVITY_CNTR_BITSZ) - 1;
	localparam soc_pkg::data_t GP0_MASK = soc_pkg::data_t'((1 << `SOC_GP0IOCOUNT) - 1);

	logic clk_2x_w;
	logic devtbl_rst2_w;
	soc_pkg::wb_req_t wb_req;
	soc_pkg::wb_rsp_t wb_rsp;
	logic [`SOC_GP0IOCOUNT-1:0] gp0_in;
	logic [`SOC_GP0IOCOUNT-1:0] gp0_out;
	logic [`SOC_GP1IOCOUNT-1:0] gp1_in;
	logic [1:0] gp_irq;
	logic activity;
	logic sys_rst;
	logic pwroff;
	int error_count;
	int activity_pulses = 0;

	tb_clkgen #(.PERIOD_NS (CLK_PERIOD_NS)) i_clkgen (.clk_o (clk_2x_w));

	soc_periph_top i_dut (
		.clk_2x_w (clk_2x_w),
		.devtbl_rst2_w (devtbl_rst2_w),
		.wb_req_i (wb_req),
		.wb_rsp_o (wb_rsp),
		.gp0_i (gp0_in),
		.gp0_o (gp0_out),
		.gp1_i (gp1_in),
		.gp_irq_o (gp_irq),
		.activity_o (activity),
		.sys_rst_o (sys_rst),
		.pwroff_o (pwroff)
	);

	// Pulses of the activity indicator, counted over the whole run
	always @(posedge clk_2x_w) begin
		if (activity === 1'b1) begin
			activity_pulses <= activity_pulses + 1;
		end
	end

	task automatic tick();
		@(posedge clk_2x_w);
		#(DRIVE_DELAY_NS);
	endtask

	task automatic report_failure(input string what);
		error_count++;
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_data(input string name, input soc_pkg::data_t got,
		input soc_pkg::data_t exp);
		if (got !== exp) begin
			report_failure($sformatf("FAILED %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_entry(input string name, input soc_pkg::devtbl_entry_t got,
		input soc_pkg::devtbl_entry_t exp);
		if (got !== exp) begin
			report_failure($sformatf("FAILED %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			report_failure($sformatf("FAILED %s: got %h expected %h", name, got, exp));
		end
	endtask

	function automatic soc_pkg::waddr_t region_addr(input int region, input int word);
		return soc_pkg::waddr_t'((region << `SOC_REGION_WBITS) + word);
	endfunction

	task automatic board_reset();
		devtbl_rst2_w = 1'b1;
		repeat (RST_HOLD_CYCLES) tick();
		devtbl_rst2_w = 1'b0;
	endtask

	// Holds the request until ack or until max_cycles have passed
	// After an ack stb stays up for the ack cycle and drops in the next one
	task automatic bus_access(input logic we, input soc_pkg::waddr_t addr,
		input soc_pkg::sel_t sel, input soc_pkg::data_t wdat, input int max_cycles,
		output soc_pkg::data_t rdat, output logic acked, output int cycles);
		acked = 1'b0;
		rdat = '0;
		cycles = 0;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we = we;
		wb_req.addr = addr;
		wb_req.sel = sel;
		wb_req.dat = wdat;
		while (!acked && cycles < max_cycles) begin
			tick();
			cycles++;
			if (wb_rsp.ack === 1'b1) begin
				acked = 1'b1;
				rdat = wb_rsp.dat;
			end
		end
		if (acked) begin
			tick();
		end
		wb_req = '0;
	endtask

	task automatic bus_read(input soc_pkg::waddr_t addr, output soc_pkg::data_t rdat);
		logic acked;
		int cycles;
		bus_access(1'b0, addr, '1, '0, ACK_WAIT_CYCLES, rdat, acked, cycles);
		if (!acked || cycles != 1) begin
			report_failure($sformatf("Read at word address %h not acknowledged in the next cycle",
				addr));
		end
	endtask

	task automatic bus_write(input soc_pkg::waddr_t addr, input soc_pkg::sel_t sel,
		input soc_pkg::data_t wdat);
		soc_pkg::data_t rdat;
		logic acked;
		int cycles;
		bus_access(1'b1, addr, sel, wdat, ACK_WAIT_CYCLES, rdat, acked, cycles);
		if (!acked || cycles != 1) begin
			report_failure($sformatf("Write at word address %h not acknowledged in the next cycle",
				addr));
		end
	endtask

	task automatic wait_sys_rst(input logic level, input int max_cycles);
		int waited;
		waited = 0;
		while (sys_rst !== level) begin
			if (waited >= max_cycles) begin
				report_failure($sformatf("sys_rst_o did not reach %0b within %0d cycles",
					level, max_cycles));
			end
			tick();
			waited++;
		end
	endtask

	task automatic test_reset_release();
		board_reset();
		for (int i = 0; i < RST_HOLDOFF; i++) begin
			check_bit("sys_rst_o", sys_rst, 1'b1);
			check_bit("wb_rsp_o.ack", wb_rsp.ack, 1'b0);
			check_bit("pwroff_o", pwroff, 1'b0);
			check_data("gp_irq_o", soc_pkg::data_t'(gp_irq), '0);
			check_data("gp0_o", soc_pkg::data_t'(gp0_out), '0);
			tick();
		end
		check_bit("sys_rst_o", sys_rst, 1'b0);
	endtask

	task automatic test_device_table();
		soc_pkg::data_t rdat;
		soc_pkg::devtbl_entry_t exp_entry [`SOC_SLAVECOUNT];
		exp_entry[`SOC_S_DEVTBL] = '{useirq: 1'b0, id: soc_pkg::dev_id_t'(`SOC_ID_DEVTBL)};
		exp_entry[`SOC_S_GP0IO] = '{useirq: 1'b1, id: soc_pkg::dev_id_t'(`SOC_ID_GPIO)};
		exp_entry[`SOC_S_GP1IO] = '{useirq: 1'b1, id: soc_pkg::dev_id_t'(`SOC_ID_GPIO)};
		exp_entry[`SOC_S_INVALID] = '{useirq: 1'b0, id: soc_pkg::dev_id_t'(`SOC_ID_INVALID)};
		for (int k = 0; k < `SOC_SLAVECOUNT; k++) begin
			bus_read(region_addr(`SOC_S_DEVTBL, k), rdat);
			check_entry($sformatf("devtbl word %0d", k),
				soc_pkg::devtbl_entry_t'(rdat[$bits(soc_pkg::devtbl_entry_t)-1:0]), exp_entry[k]);
			check_data("devtbl upper bits", rdat >> $bits(soc_pkg::devtbl_entry_t), '0);
		end
	endtask

	task automatic test_gpio();
		soc_pkg::data_t model;
		soc_pkg::data_t wdat;
		soc_pkg::data_t mask;
		soc_pkg::data_t rdat;
		soc_pkg::sel_t sel;
		logic [`SOC_GP1IOCOUNT-1:0] in_val;
		int irq_count;
		int first_irq;
		// Known start value with every byte enabled
		model = 32'h0000_a5c3;
		bus_write(region_addr(`SOC_S_GP0IO, 1), '1, model);
		check_data("gp0_o", soc_pkg::data_t'(gp0_out), model & GP0_MASK);
		for (int n = 0; n < 8; n++) begin
			wdat = $urandom;
			sel = soc_pkg::sel_t'($urandom_range(15, 0));
			for (int b = 0; b < `SOC_ARCHBITSZ / 8; b++) begin
				mask[b*8 +: 8] = {8{sel[b]}};
			end
			model = (model & ~mask) | (wdat & mask);
			bus_write(region_addr(`SOC_S_GP0IO, 1), sel, wdat);
			check_data("gp0_o", soc_pkg::data_t'(gp0_out), model & GP0_MASK);
			bus_read(region_addr(`SOC_S_GP0IO, 1), rdat);
			check_data("gp0 word 1", rdat, model & GP0_MASK);
		end
		for (int n = 0; n < 6; n++) begin
			in_val = gp1_in ^ `SOC_GP1IOCOUNT'($urandom_range((1 << `SOC_GP1IOCOUNT) - 1, 1));
			gp1_in = in_val;
			irq_count = 0;
			first_irq = 0;
			for (int c = 1; c <= 6; c++) begin
				tick();
				check_bit("gp_irq_o[0]", gp_irq[0], 1'b0);
				if (gp_irq[1] === 1'b1) begin
					irq_count++;
					if (first_irq == 0) begin
						first_irq = c;
					end
				end
			end
			check_data("gp_irq_o[1] pulses", soc_pkg::data_t'(irq_count), 32'd1);
			if (first_irq > 3) begin
				report_failure("GPIO input change interrupt came later than 3 cycles");
			end
			bus_read(region_addr(`SOC_S_GP1IO, 0), rdat);
			check_data("gp1 word 0", rdat, soc_pkg::data_t'(in_val));
		end
	endtask

	task automatic test_invalid_region();
		soc_pkg::data_t rdat;
		logic acked;
		int cycles;
		bus_access(1'b0, region_addr(5, 0), '1, '0, ACK_WAIT_CYCLES, rdat, acked, cycles);
		check_bit("wb_rsp_o.ack for region 5", acked, 1'b0);
		repeat (2) tick();
		// The bus still works after the abandoned access
		bus_read(region_addr(`SOC_S_DEVTBL, 0), rdat);
	endtask

	task automatic test_software_reset();
		int high_cycles;
		// Warm reset request
		bus_write(region_addr(`SOC_S_DEVTBL, 0), '1, 32'd2);
		wait_sys_rst(1'b1, 4);
		high_cycles = 0;
		while (sys_rst === 1'b1 && high_cycles <= 2 * RST_HOLDOFF) begin
			high_cycles++;
			tick();
		end
		check_data("sys_rst_o high cycles", soc_pkg::data_t'(high_cycles),
			soc_pkg::data_t'(RST_HOLDOFF));
		check_bit("pwroff_o", pwroff, 1'b0);
		// Power-off request, held until the board reset
		bus_write(region_addr(`SOC_S_DEVTBL, 0), '1, 32'd1);
		tick();
		repeat (20) begin
			check_bit("pwroff_o", pwroff, 1'b1);
			check_bit("sys_rst_o", sys_rst, 1'b1);
			tick();
		end
		board_reset();
		check_bit("pwroff_o", pwroff, 1'b0);
		wait_sys_rst(1'b0, RST_HOLDOFF + 4);
	endtask

	task automatic test_activity();
		soc_pkg::data_t rdat;
		int base;
		repeat (BLANK_CYCLES + 3) tick();
		base = activity_pulses;
		bus_read(region_addr(`SOC_S_DEVTBL, 0), rdat);
		repeat (20) tick();
		bus_read(region_addr(`SOC_S_DEVTBL, 1), rdat);
		repeat (4) tick();
		check_data("activity_o pulses", soc_pkg::data_t'(activity_pulses - base), 32'd1);
		repeat (BLANK_CYCLES + 3) tick();
		bus_read(region_addr(`SOC_S_DEVTBL, 2), rdat);
		repeat (4) tick();
		check_data("activity_o pulses", soc_pkg::data_t'(activity_pulses - base), 32'd2);
	endtask

	initial begin
		void'($urandom(82346));
		error_count = 0;
		devtbl_rst2_w = 1'b1;
		wb_req = '0;
		gp0_in = 16'h3c5a;
		gp1_in = '0;
		test_reset_release();
		test_device_table();
		test_gpio();
		test_invalid_region();
		test_software_reset();
		test_activity();
		if (error_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog sized from the number of tests
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
		$display("TEST FAILED");
		$fatal(1, "Watchdog timeout");
	end

endmodule

// ==== verification/wbpi_props.sv ====
// Protocol assertions on the peripheral bus decoder, with their bind statement
`timescale 1ns/100ps
`include "soc_defines.svh"

module wbpi_props (
	input logic clk_2x_w,
	input logic sys_rst_i,
	input soc_pkg::wb_req_t m_req_i,
	input soc_pkg::wb_rsp_t m_rsp_i,
	input soc_pkg::wb_req_t s_req_i [`SOC_SLAVECOUNT]
);

	localparam int REGION_BITSZ = `SOC_ADDRBITSZ - `SOC_REGION_WBITS;

	logic [REGION_BITSZ-1:0] region;
	logic [`SOC_SLAVECOUNT-1:0] slv_stb;
	logic [`SOC_SLAVECOUNT-1:0] exp_stb;
	logic region_invalid;

	always_comb begin
		for (int i = 0; i < `SOC_SLAVECOUNT; i++) begin
			slv_stb[i] = s_req_i[i].stb;
		end
	end

	assign region = m_req_i.addr[`SOC_ADDRBITSZ-1:`SOC_REGION_WBITS];

	// Regions from the invalid index upward have no device behind them
	assign region_invalid = region >= REGION_BITSZ'(`SOC_S_INVALID);

	// Only the addressed slave may see the strobe, none while in reset
	always_comb begin
		exp_stb = '0;
		if (m_req_i.stb && !sys_rst_i) begin
			if (region_invalid) begin
				exp_stb[`SOC_S_INVALID] = 1'b1;
			end else begin
				exp_stb[soc_pkg::slv_idx_t'(region)] = 1'b1;
			end
		end
	end

	ack_after_stb: assert property (@(posedge clk_2x_w) disable iff (sys_rst_i)
		m_rsp_i.ack |-> $past(m_req_i.stb))
		else $error("ack seen without a strobe in the previous cycle");

	one_slave_stb: assert property (@(posedge clk_2x_w) slv_stb == exp_stb)
		else $error("slave strobes do not match the addressed slave");

	no_invalid_ack: assert property (@(posedge clk_2x_w) disable iff (sys_rst_i)
		region_invalid |-> !m_rsp_i.ack)
		else $error("ack returned for the invalid region");

endmodule

bind wbpi_decoder wbpi_props i_wbpi_props (
	.clk_2x_w (clk_2x_w),
	.sys_rst_i (sys_rst_i),
	.m_req_i (m_req_i),
	.m_rsp_i (m_rsp_o),
	.s_req_i (s_req_o)
);
